// File: src/cacheGeomPkg.sv
// Geometry of the direct-mapped read cache and the two views of a word address
// Imported by the controller, both stores and main memory
package cacheGeomPkg;

    localparam int TagWidth    = 3;  // Upper address bits kept per line
    localparam int IndexWidth  = 5;  // Selects one of the cache lines
    localparam int OffsetWidth = 2;  // Word within a block
    localparam int DataWidth   = 16; // Processor word

    localparam int AddrWidth  = TagWidth + IndexWidth + OffsetWidth;
    localparam int LineCount  = 2 ** IndexWidth;      // 32 lines
    localparam int BlockWords = 2 ** OffsetWidth;     // 4 words per line
    localparam int CacheWords = LineCount * BlockWords;
    localparam int MemWords   = 2 ** AddrWidth;       // Full backing memory

    // Cache view of an address, tag in the top bits
    typedef struct packed {
        logic [TagWidth-1:0]    tag;
        logic [IndexWidth-1:0]  index;
        logic [OffsetWidth-1:0] offset;
    } cacheFields;

    // Same bits seen flat by memory or split by the cache
    typedef union packed {
        logic [AddrWidth-1:0] word; // Main memory word address
        cacheFields           fields;
    } cacheAddr;

endpackage

// File: src/cacheBusPkg.sv
// Processor request and response words, and the controller drive to the stores
// Shared by the cache top level, the controller and the storage blocks
package cacheBusPkg;

    // Held by the processor until busy reads low
    typedef struct packed {
        logic                                read;      // Read level
        logic                                write;     // Write level
        cacheGeomPkg::cacheAddr              addr;      // Word address
        logic [cacheGeomPkg::DataWidth-1:0]  writeData; // Data for writes
    } cacheRequest;

    typedef struct packed {
        logic                                busy;     // Request not taken
        logic                                hit;      // Read data valid
        logic [cacheGeomPkg::DataWidth-1:0]  readData; // Word from the cache
    } cacheResponse;

    // One command per cycle, seen by tag store, data store and memory
    typedef struct packed {
        cacheGeomPkg::cacheAddr addr;       // Target of every strobe below
        logic                   cacheWrite; // Data word write, tag update at block end
        logic                   cacheClear; // Invalidate the indexed line
        logic                   memRead;    // Memory word wanted
        logic                   memWrite;   // Write-through to memory
    } storeCommand;

endpackage

// File: src/cacheController.sv
`timescale 1ns/1ps
// Read cache FSM that clears all lines after reset, serves lookups and fills missed blocks
// Drives one store command per cycle to the tag store, data store and main memory

module cacheController (
    input  logic                     i_clock,   // Clock
    input  logic                     i_reset,   // Sync reset, active high
    input  cacheBusPkg::cacheRequest i_request, // Processor request levels
    input  logic                     i_hit,     // Tag store compare result
    output cacheBusPkg::storeCommand o_command, // To stores and memory
    output logic                     o_fill,    // Data store takes the memory word
    output logic                     o_busy,    // Request ignored this cycle
    output logic                     o_hit      // Hit as seen by the processor
);
    import cacheGeomPkg::*;

    typedef enum logic [1:0] {
        StateReset,  // One cycle before clearing
        StateClear,  // One line per cycle
        StateLookup, // Idle, serving requests
        StateRead    // Block fill, one word per cycle
    } controllerState;

    controllerState state;
    controllerState nextState;

    logic [TagWidth-1:0]    tagCount;        // Tag of the block being filled
    logic [TagWidth-1:0]    nextTagCount;
    logic [IndexWidth-1:0]  indexCount;      // Clear walk and fill line
    logic [IndexWidth-1:0]  nextIndexCount;
    logic [OffsetWidth-1:0] offsetCount;     // Word within the fill
    logic [OffsetWidth-1:0] nextOffsetCount;

    // ----------------------------------------
    // Next state and command decode
    // ----------------------------------------
    always_comb begin
        o_command      = '0;
        o_command.addr = i_request.addr; // Pass-through unless a state overrides
        o_fill         = 1'b0;
        o_busy         = 1'b1;           // Only LOOKUP takes requests
        o_hit          = 1'b0;

        nextState       = state;
        nextTagCount    = tagCount;
        nextIndexCount  = indexCount;
        nextOffsetCount = offsetCount;

        case (state)
            StateReset: begin
                nextIndexCount = '0;
                nextState      = StateClear;
            end

            StateClear: begin
                o_command.addr.fields = '{tag: '0, index: indexCount, offset: '0};
                o_command.cacheClear  = 1'b1;
                nextIndexCount = indexCount + IndexWidth'(1);
                if (indexCount == '1) begin // Last line done
                    nextState = StateLookup;
                end
            end

            StateLookup: begin
                o_busy             = 1'b0;
                o_hit              = i_hit;
                o_command.memRead  = i_request.read;
                o_command.memWrite = i_request.write;  // Write-through on every write
                // No allocate so the cache word changes only on a hit
                // and a miss never overwrites another tag's line
                o_command.cacheWrite = i_request.write & i_hit;
                if (i_request.read && !i_hit) begin
                    nextTagCount    = i_request.addr.fields.tag;
                    nextIndexCount  = i_request.addr.fields.index;
                    nextOffsetCount = '0; // Fill always starts at word 0
                    nextState       = StateRead;
                end
            end

            StateRead: begin
                o_command.addr.fields = '{tag: tagCount, index: indexCount,
                                          offset: offsetCount};
                o_command.cacheWrite = 1'b1;
                o_command.memRead    = 1'b1;
                o_fill               = 1'b1; // Memory word into the data store
                nextOffsetCount = offsetCount + OffsetWidth'(1);
                if (offsetCount == '1) begin
                    nextState = StateLookup; // Held read hits next cycle
                end
            end

            default: begin
                nextState = StateReset;
            end
        endcase
    end

    // ----------------------------------------
    // State and counter registers
    // ----------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state       <= StateReset;
            tagCount    <= '0;
            indexCount  <= '0;
            offsetCount <= '0;
        end else begin
            state       <= nextState;
            tagCount    <= nextTagCount;
            indexCount  <= nextIndexCount;
            offsetCount <= nextOffsetCount;
        end
    end

    // Read miss leaves LOOKUP so the processor sees busy from the next edge
    assert property (@(posedge i_clock) disable iff (i_reset)
        (state == StateLookup && i_request.read && !i_hit) |=> o_busy);

    // One kind of request at a time on the port
    assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_request.read && i_request.write));

endmodule

// File: src/cacheTagStore.sv
`timescale 1ns/1ps
// Valid bit and tag per cache line, with the hit compare for the command address
// Written by the controller during clear and at the end of each block fill

module cacheTagStore (
    input  logic                     i_clock,   // Clock
    input  cacheBusPkg::storeCommand i_command, // From the controller
    output logic                     o_hit      // Valid and tag match
);
    import cacheGeomPkg::*;

    logic [LineCount-1:0] lineValid;            // One bit per line
    logic [TagWidth-1:0]  lineTag [LineCount];  // Owner tag per line
    cacheFields           fields;               // Split command address

    assign fields = i_command.addr.fields;

    // Combinational compare in the same cycle as the request
    assign o_hit = lineValid[fields.index] && (lineTag[fields.index] == fields.tag);

    always_ff @(posedge i_clock) begin
        if (i_command.cacheClear) begin
            lineValid[fields.index] <= 1'b0;
        end else if (i_command.cacheWrite && (fields.offset == '1)) begin
            // Last word of a fill claims the line
            // A write hit here rewrites the same tag
            lineValid[fields.index] <= 1'b1;
            lineTag[fields.index]   <= fields.tag;
        end
    end

    // Clear walk and fills never overlap
    assert property (@(posedge i_clock)
        !(i_command.cacheClear && i_command.cacheWrite));

endmodule

// File: src/cacheDataStore.sv
`timescale 1ns/1ps
// Cache data words, one block per line, addressed by index and offset
// Read combinationally for hits, written on the controller's cacheWrite

module cacheDataStore (
    input  logic                                 i_clock,     // Clock
    input  cacheBusPkg::storeCommand             i_command,   // From the controller
    input  logic [cacheGeomPkg::DataWidth-1:0]   i_writeData, // Fill or processor word
    output logic [cacheGeomPkg::DataWidth-1:0]   o_readData   // Word at command address
);
    import cacheGeomPkg::*;

    logic [DataWidth-1:0]               words [CacheWords]; // Line-major storage
    logic [IndexWidth+OffsetWidth-1:0]  wordSel;            // Index then offset

    assign wordSel    = {i_command.addr.fields.index, i_command.addr.fields.offset};
    assign o_readData = words[wordSel];

    always_ff @(posedge i_clock) begin
        if (i_command.cacheWrite) begin
            words[wordSel] <= i_writeData;
        end
    end

endmodule

// File: src/mainMemory.sv
`timescale 1ns/1ps
// Backing store behind the cache, addressed by the flat word view of the address
// Single cycle read, write at the clock edge

module mainMemory (
    input  logic                                 i_clock,     // Clock
    input  cacheBusPkg::storeCommand             i_command,   // From the controller
    input  logic [cacheGeomPkg::DataWidth-1:0]   i_writeData, // Write-through data
    output logic [cacheGeomPkg::DataWidth-1:0]   o_readData   // Word at command address
);
    import cacheGeomPkg::*;

    logic [DataWidth-1:0] words [MemWords]; // Full address space

    // No read latency so a fill takes one word per cycle
    assign o_readData = words[i_command.addr.word];

    always_ff @(posedge i_clock) begin
        if (i_command.memWrite) begin
            words[i_command.addr.word] <= i_writeData;
        end
    end

    // Single port with one access per cycle
    assert property (@(posedge i_clock)
        !(i_command.memWrite && i_command.memRead));

endmodule

// File: src/cacheTop.sv
`timescale 1ns/1ps
// Read cache subsystem top: controller, tag store, data store and main memory
// Processor drives a request word and samples the response word

module cacheTop (
    input  logic                      i_clock,    // Clock
    input  logic                      i_reset,    // Sync reset, active high
    input  cacheBusPkg::cacheRequest  i_request,  // Processor request
    output cacheBusPkg::cacheResponse o_response  // Busy, hit and read data
);
    import cacheGeomPkg::*;
    import cacheBusPkg::*;

    storeCommand          command;        // Shared by all storage blocks
    logic                 fill;           // Fill select from the controller
    logic                 tagHit;         // Raw compare
    logic                 busy;
    logic                 hit;            // Gated by the controller
    logic [DataWidth-1:0] memReadData;
    logic [DataWidth-1:0] cacheReadData;
    logic [DataWidth-1:0] cacheWriteData;

    // ----------------------------------------
    // Data paths
    // ----------------------------------------
    assign cacheWriteData = fill ? memReadData : i_request.writeData; // Fill or write hit

    assign o_response = '{busy: busy, hit: hit, readData: cacheReadData};

    // ----------------------------------------
    // Instances
    // ----------------------------------------
    cacheController controller_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_request (i_request),
        .i_hit     (tagHit),
        .o_command (command),
        .o_fill    (fill),
        .o_busy    (busy),
        .o_hit     (hit)
    );

    cacheTagStore tagStore_i (
        .i_clock   (i_clock),
        .i_command (command),
        .o_hit     (tagHit)
    );

    cacheDataStore dataStore_i (
        .i_clock     (i_clock),
        .i_command   (command),
        .i_writeData (cacheWriteData),
        .o_readData  (cacheReadData)
    );

    mainMemory memory_i (
        .i_clock     (i_clock),
        .i_command   (command),
        .i_writeData (i_request.writeData), // Memory only sees processor writes
        .o_readData  (memReadData)
    );

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ps
// Testbench clock and reset source for the cache testbench
// 20 ns clock, synchronous reset held for the first 10 rising edges

module clockGen (
    output logic o_clock, // Free-running clock
    output logic o_reset  // Active high, released on an edge
);
    localparam int ResetCycles = 10;

    initial begin
        o_clock = 1'b0;
        forever #10 o_clock = ~o_clock; // Half of the 20 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (ResetCycles) @(posedge o_clock);
        o_reset <= 1'b0; // Released at a rising edge like any other input
    end

endmodule

// File: verif/cacheTb.sv
`timescale 1ns/1ps
// Read cache testbench with random reads and writes checked against a memory and tag model
// Run through tb.f, top module cacheTb

module cacheTb;
    import cacheGeomPkg::*;
    import cacheBusPkg::*;

    localparam int RandomOps      = 2000;
    localparam int ConflictRounds = 32;
    // 43 reset and clear, 1024 preload, 3*32 + 2000 ops at up to 6 cycles
    localparam int TimeoutCycles  = 20000;

    logic         clock;
    logic         reset;
    cacheRequest  request;
    cacheResponse response;

    // Reference model
    logic [DataWidth-1:0] memModel [MemWords];   // Expected memory contents
    logic                 validModel [LineCount];
    logic [TagWidth-1:0]  tagModel [LineCount];

    int       errorCount;
    int       checkCount;
    int       cycleCount;
    int       seed;
    int       busyCycles;
    logic     firstHit;   // Hit seen in the first LOOKUP cycle of a read
    logic     [31:0] pick;
    cacheAddr target;
    cacheAddr lastAddr;
    cacheAddr newAddr;

    clockGen clockGen_i (
        .o_clock (clock),
        .o_reset (reset)
    );

    cacheTop cacheTop_i (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_request  (request),
        .o_response (response)
    );

    // ----------------------------------------
    // Checks and timeout
    // ----------------------------------------
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: test sequence not finished after %0d cycles", cycleCount);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic expectHit(input cacheAddr addr);
        return validModel[addr.fields.index] && (tagModel[addr.fields.index] == addr.fields.tag);
    endfunction

    // ----------------------------------------
    // Processor side operations
    // ----------------------------------------
    // Read held until it hits and a miss fills in exactly 4 busy cycles
    task automatic readWord(input cacheAddr addr, output logic hitFirst);
        logic hitExpected;
        int   fillCycles;
        @(posedge clock);
        request <= '{read: 1'b1, write: 1'b0, addr: addr, writeData: '0};
        @(negedge clock);
        while (response.busy) @(negedge clock); // Bounded by the timeout
        hitExpected = expectHit(addr);
        hitFirst    = response.hit;
        checkValue("hit", 32'(response.hit), 32'(hitExpected));
        if (!hitExpected) begin
            validModel[addr.fields.index] = 1'b1; // Fill claims the line
            tagModel[addr.fields.index]   = addr.fields.tag;
            fillCycles = 0;
            @(negedge clock);
            while (response.busy) begin
                fillCycles++;
                @(negedge clock);
            end
            checkValue("fill busy cycles", fillCycles, 4);
            checkValue("hit after fill", 32'(response.hit), 32'd1);
        end
        checkValue("readData", 32'(response.readData), 32'(memModel[addr.word]));
    endtask

    // Write-through write taken at the next edge
    task automatic writeWord(input cacheAddr addr, input logic [DataWidth-1:0] data);
        @(posedge clock);
        request <= '{read: 1'b0, write: 1'b1, addr: addr, writeData: data};
        @(negedge clock);
        while (response.busy) @(negedge clock);
        checkValue("hit on write", 32'(response.hit), 32'(expectHit(addr)));
        memModel[addr.word] = data; // No allocate, tags unchanged
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        request    = '0;
        seed       = 1;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        lastAddr   = '0;
        for (int i = 0; i < LineCount; i++) begin
            validModel[i] = 1'b0;
            tagModel[i]   = '0;
        end

        // Busy through 1 RESET and 32 CLEAR cycles
        @(negedge clock);
        while (reset) @(negedge clock);
        busyCycles = 0;
        while (response.busy && busyCycles < 100) begin
            checkValue("hit during clear", 32'(response.hit), 32'd0);
            busyCycles++;
            @(negedge clock);
        end
        checkValue("busy cycles after reset", busyCycles, 33);

        // Preload every word, all write misses
        for (int a = 0; a < MemWords; a++) begin
            target.word = AddrWidth'(a);
            writeWord(target, DataWidth'($random(seed)));
        end

        // Same index with another tag evicts the line
        for (int n = 0; n < ConflictRounds; n++) begin
            target.word = AddrWidth'($random(seed));
            newAddr = target;
            newAddr.fields.tag = target.fields.tag + TagWidth'(1);
            readWord(target, firstHit);
            readWord(newAddr, firstHit);
            readWord(target, firstHit);
            checkValue("hit on evicted tag", 32'(firstHit), 32'd0);
        end

        // Random mix with half of the addresses in the last block touched
        for (int n = 0; n < RandomOps; n++) begin
            pick = $random(seed);
            if (pick[0]) begin
                target = lastAddr;
                target.fields.offset = OffsetWidth'($random(seed));
            end else begin
                target.word = AddrWidth'($random(seed));
            end
            if (pick[3:1] < 3'd5) begin // About 60 percent reads
                readWord(target, firstHit);
            end else begin
                writeWord(target, DataWidth'($random(seed)));
            end
            lastAddr = target;
        end

        @(posedge clock);
        request <= '0; // Last write completes here
        @(negedge clock);
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
src/cacheGeomPkg.sv
src/cacheBusPkg.sv
src/cacheController.sv
src/cacheTagStore.sv
src/cacheDataStore.sv
src/mainMemory.sv
src/cacheTop.sv
verif/clockGen.sv
verif/cacheTb.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cacheTb

output=$(./obj_dir/VcacheTb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
